// ==== project.f ====
verilog/textOverlayPkg.sv
verilog/characterTable.sv
verilog/characterLocator.sv
verilog/fontMemory.sv
verilog/videoDelayLine.sv
verilog/pixelCompositor.sv
verilog/textOverlayTop.sv
verification/textOverlay_assertions.sv
verification/textOverlayTb.sv

// ==== verification/textOverlayTb.sv ====
`timescale 1ns/1ns

module textOverlayTb;
    import textOverlayPkg::*;

    localparam int characterCount = 8;
    localparam int windowX = 320;  // slots land in a 64 by 64 window here
    localparam int windowY = 160;
    localparam int drainLimit = 50;

    typedef struct {
        int due;
        logic [displayXBits-1:0] x;
        logic [displayYBits-1:0] y;
        logic hsync;
        logic vsync;
        logic blank;
        logic [colorBits-1:0] pixel;
    } expectedOutput;

    logic clock;
    logic reset;
    logic [displayXBits-1:0] displayX;
    logic [displayYBits-1:0] displayY;
    logic hsync;
    logic vsync;
    logic blank;
    logic [colorBits-1:0] previousPixel;
    logic configWrite;
    logic [configAddressBits-1:0] configAddress;
    configWord configData;
    logic [displayXBits-1:0] displayXOut;
    logic [displayYBits-1:0] displayYOut;
    logic hsyncOut;
    logic vsyncOut;
    logic blankOut;
    logic [colorBits-1:0] pixel;

    slotEntry modelSlots [characterCount];
    glyphRowBits modelGlyphs [2 ** $bits(glyphRowAddress)];
    logic [codeBits-1:0] glyphCodes [$];
    expectedOutput expectedQueue [$];
    int cycle;
    string testName;

    textOverlayTop #(
        .characterCount(characterCount)
    ) dut (
        .clock(clock),
        .reset(reset),
        .displayX(displayX),
        .displayY(displayY),
        .hsync(hsync),
        .vsync(vsync),
        .blank(blank),
        .previousPixel(previousPixel),
        .configWrite(configWrite),
        .configAddress(configAddress),
        .configData(configData),
        .displayXOut(displayXOut),
        .displayYOut(displayYOut),
        .hsyncOut(hsyncOut),
        .vsyncOut(vsyncOut),
        .blankOut(blankOut),
        .pixel(pixel)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic stopWithFailure(input string reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkValue(input string field, input logic [31:0] expected,
            input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s %s: expected %0h, actual %0h", testName, field, expected, actual);
            stopWithFailure("output mismatch");
        end
    endtask

    // highest enabled slot covering the pixel decides
    function automatic logic [colorBits-1:0] modelPixel(input int x, input int y,
            input logic [colorBits-1:0] background);
        logic [colorBits-1:0] result;
        glyphRowBits row;
        result = background;
        for (int i = 0; i < characterCount; i++) begin
            if (modelSlots[i].enable && x >= modelSlots[i].x && x < modelSlots[i].x + glyphWidth &&
                y >= modelSlots[i].y && y < modelSlots[i].y + glyphHeight) begin
                row = modelGlyphs[{modelSlots[i].code, rowBits'(y - modelSlots[i].y)}];
                result = row[x - modelSlots[i].x] ? modelSlots[i].color : background;
            end
        end
        return result;
    endfunction

    task automatic advance();
        expectedOutput front;
        @(negedge clock);
        cycle++;
        assert (dut.assertions0.failureCount == 0) else begin
            $display("Bound timing assertion failed during %s", testName);
            stopWithFailure("timing assertion failure");
        end
        if (expectedQueue.size() != 0 && expectedQueue[0].due == cycle) begin
            front = expectedQueue.pop_front();
            checkValue("displayXOut", front.x, displayXOut);
            checkValue("displayYOut", front.y, displayYOut);
            checkValue("hsyncOut", front.hsync, hsyncOut);
            checkValue("vsyncOut", front.vsync, vsyncOut);
            checkValue("blankOut", front.blank, blankOut);
            checkValue("pixel", front.pixel, pixel);
        end
    endtask

    task automatic drivePixel(input int x, input int y);
        expectedOutput entry;
        advance();
        configWrite = 1'b0;
        displayX = displayXBits'(x);
        displayY = displayYBits'(y);
        hsync = 1'($urandom);
        vsync = 1'($urandom);
        blank = 1'($urandom);
        previousPixel = colorBits'($urandom);
        entry.due = cycle + pipelineLatency;
        entry.x = displayX;
        entry.y = displayY;
        entry.hsync = hsync;
        entry.vsync = vsync;
        entry.blank = blank;
        entry.pixel = modelPixel(displayX, displayY, previousPixel);
        expectedQueue.push_back(entry);
    endtask

    task automatic driveIdle();
        advance();
        configWrite = 1'b0;
        displayX = '0;
        displayY = '0;
        hsync = 1'b0;
        vsync = 1'b0;
        blank = 1'b0;
        previousPixel = '0;
    endtask

    task automatic drainPipeline();
        int guard;
        guard = 0;
        while (expectedQueue.size() != 0) begin
            if (guard == drainLimit) begin
                $display("Timeout: outputs still pending after %0d idle cycles", drainLimit);
                stopWithFailure("pipeline did not drain");
            end
            driveIdle();
            guard++;
        end
    endtask

    task automatic writeConfig(input logic [configAddressBits-1:0] address, input configWord data);
        advance();
        configWrite = 1'b1;
        configAddress = address;
        configData = data;
        if (!address[configAddressBits-1]) begin
            modelGlyphs[address[$bits(glyphRowAddress)-1:0]] = data.glyph.row;
        end else if (address[configAddressBits-2:0] < characterCount) begin
            modelSlots[address[configAddressBits-2:0]] = data.slot;
        end
    endtask

    task automatic writeSlot(input int index, input slotEntry entry);
        logic [configAddressBits-1:0] address;
        configWord data;
        address = configAddressBits'(index);
        address[configAddressBits-1] = 1'b1;
        data.slot = entry;
        writeConfig(address, data);
    endtask

    function automatic slotEntry randomSlot();
        slotEntry entry;
        entry.enable = ($urandom % 4) != 0;
        entry.x = displayXBits'(windowX + $urandom % (64 - glyphWidth));
        entry.y = displayYBits'(windowY + $urandom % (64 - glyphHeight));
        entry.code = glyphCodes[$urandom % glyphCodes.size()];
        entry.color = colorBits'($urandom);
        return entry;
    endfunction

    task automatic runWindowPixels(input int count);
        repeat (count) drivePixel(windowX - 4 + $urandom % 72, windowY - 4 + $urandom % 72);
        drainPipeline();
    endtask

    initial begin
        int start;
        logic [63:0] randomBits;
        slotEntry lower;
        slotEntry upper;
        void'($urandom(99785));
        reset = 1'b1;
        configWrite = 1'b0;
        configAddress = '0;
        configData = '0;
        displayX = '0;
        displayY = '0;
        hsync = 1'b0;
        vsync = 1'b0;
        blank = 1'b0;
        previousPixel = '0;
        cycle = 0;
        foreach (modelSlots[i]) modelSlots[i] = '0;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        testName = "resetState";
        checkValue("hsyncOut", 32'd0, hsyncOut);
        checkValue("vsyncOut", 32'd0, vsyncOut);
        checkValue("blankOut", 32'd0, blankOut);
        checkValue("pixel", 32'd0, pixel);

        testName = "passThrough";  // every slot still disabled
        repeat (200) drivePixel($urandom % 4096, $urandom % 4096);
        drainPipeline();

        testName = "glyphPaint";
        start = $urandom % 128;
        for (int k = 0; k < 6; k++) glyphCodes.push_back(codeBits'(start + 17 * k));
        foreach (glyphCodes[c]) begin
            for (int row = 0; row < glyphHeight; row++) begin
                randomBits = {$urandom, $urandom};  // upper word bits are junk
                writeConfig({glyphCodes[c], rowBits'(row)}, randomBits[$bits(configWord)-1:0]);
            end
        end
        for (int i = 0; i < characterCount; i++) writeSlot(i, randomSlot());
        writeSlot(characterCount + 3, randomSlot());  // out of range index is dropped
        driveIdle();
        runWindowPixels(600);

        testName = "overlapPriority";
        lower = randomSlot();
        lower.enable = 1'b1;
        upper = randomSlot();
        upper.enable = 1'b1;
        upper.x = lower.x;
        upper.y = lower.y;
        writeSlot(0, lower);
        writeSlot(characterCount - 1, upper);
        driveIdle();
        repeat (150) drivePixel(lower.x + $urandom % glyphWidth, lower.y + $urandom % glyphHeight);
        drainPipeline();

        testName = "cellEdges";
        for (int i = 0; i < characterCount; i++) begin
            if (modelSlots[i].enable) begin
                drivePixel(modelSlots[i].x + glyphWidth - 1, modelSlots[i].y + glyphHeight - 1);
                drivePixel(modelSlots[i].x + glyphWidth, modelSlots[i].y);
                drivePixel(modelSlots[i].x, modelSlots[i].y + glyphHeight);
                drivePixel(modelSlots[i].x - 1, modelSlots[i].y);
                drivePixel(modelSlots[i].x, modelSlots[i].y - 1);
                drivePixel(modelSlots[i].x, modelSlots[i].y);
            end
        end
        drainPipeline();

        testName = "rewriteSlot";
        repeat (3) begin
            for (int i = 0; i < characterCount; i++) writeSlot(i, randomSlot());
            driveIdle();
            runWindowPixels(300);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== verification/textOverlay_assertions.sv ====
`timescale 1ns/1ns

module textOverlayAssertions (
    input logic clock,
    input logic reset,
    input logic hsync,
    input logic vsync,
    input logic blank,
    input logic hsyncOut,
    input logic vsyncOut,
    input logic blankOut,
    input logic configWrite,
    input logic [textOverlayPkg::configAddressBits-1:0] configAddress,
    input logic glyphWrite
);
    import textOverlayPkg::*;

    int settledCycles;  // edges since reset up to the latency
    int failureCount = 0;  // failed assertions so far

    always_ff @(posedge clock) begin
        if (reset) begin
            settledCycles <= 0;
        end else if (settledCycles < pipelineLatency) begin
            settledCycles <= settledCycles + 1;
        end
    end

    hsyncDelay: assert property (@(posedge clock) disable iff (reset)
        settledCycles == pipelineLatency |-> hsyncOut == $past(hsync, pipelineLatency))
        else begin
            failureCount++;
            $error("hsyncOut does not follow hsync by the pipeline latency");
        end

    vsyncDelay: assert property (@(posedge clock) disable iff (reset)
        settledCycles == pipelineLatency |-> vsyncOut == $past(vsync, pipelineLatency))
        else begin
            failureCount++;
            $error("vsyncOut does not follow vsync by the pipeline latency");
        end

    blankDelay: assert property (@(posedge clock) disable iff (reset)
        settledCycles == pipelineLatency |-> blankOut == $past(blank, pipelineLatency))
        else begin
            failureCount++;
            $error("blankOut does not follow blank by the pipeline latency");
        end

    // memory write strobe only right after a glyph space write
    glyphWritePulse: assert property (@(posedge clock) disable iff (reset)
        settledCycles != 0 |->
            glyphWrite == $past(configWrite && !configAddress[configAddressBits-1]))
        else begin
            failureCount++;
            $error("glyphWrite does not match a glyph write one cycle earlier");
        end

endmodule

bind textOverlayTop textOverlayAssertions assertions0 (.*);

// ==== verilog/characterLocator.sv ====
`timescale 1ns/1ns

module characterLocator #(
    parameter int characterCount = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic [textOverlayPkg::displayXBits-1:0] displayX,
    input  logic [textOverlayPkg::displayYBits-1:0] displayY,
    input  textOverlayPkg::slotEntry [characterCount-1:0] slots,
    output textOverlayPkg::glyphRowAddress glyphReadAddress,
    output logic hit,
    output logic [textOverlayPkg::columnBits-1:0] hitColumn,
    output logic [textOverlayPkg::colorBits-1:0] hitColor
);
    import textOverlayPkg::*;

    localparam int indexBits = characterCount > 1 ? $clog2(characterCount) : 1;
    localparam logic [displayXBits-1:0] cellWidth = displayXBits'(glyphWidth);
    localparam logic [displayYBits-1:0] cellHeight = displayYBits'(glyphHeight);

    logic matchFound;
    logic [indexBits-1:0] matchIndex;
    logic [rowBits-1:0] matchRow;
    logic [columnBits-1:0] matchColumn;

    logic hitStage1;
    logic [indexBits-1:0] indexStage1;
    logic [rowBits-1:0] rowStage1;
    logic [columnBits-1:0] columnStage1;

    // later slots override earlier ones, so the highest index wins
    always_comb begin
        logic [displayXBits-1:0] offsetX;
        logic [displayYBits-1:0] offsetY;
        matchFound = 1'b0;
        matchIndex = '0;
        matchRow = '0;
        matchColumn = '0;
        for (int i = 0; i < characterCount; i++) begin
            offsetX = displayX - slots[i].x;
            offsetY = displayY - slots[i].y;
            if (slots[i].enable && displayX >= slots[i].x && offsetX < cellWidth &&
                displayY >= slots[i].y && offsetY < cellHeight) begin
                matchFound = 1'b1;
                matchIndex = indexBits'(i);
                matchRow = offsetY[rowBits-1:0];
                matchColumn = offsetX[columnBits-1:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            hitStage1 <= 1'b0;
            indexStage1 <= '0;
            rowStage1 <= '0;
            columnStage1 <= '0;
            hit <= 1'b0;
            glyphReadAddress <= '0;
            hitColumn <= '0;
            hitColor <= '0;
        end else begin
            hitStage1 <= matchFound;
            indexStage1 <= matchIndex;
            rowStage1 <= matchRow;
            columnStage1 <= matchColumn;
            // second stage reads the winner only
            hit <= hitStage1;
            glyphReadAddress <= {slots[indexStage1].code, rowStage1};
            hitColumn <= columnStage1;
            hitColor <= slots[indexStage1].color;
        end
    end

endmodule

// ==== verilog/characterTable.sv ====
`timescale 1ns/1ns

module characterTable #(
    parameter int characterCount = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic configWrite,
    input  logic [textOverlayPkg::configAddressBits-1:0] configAddress,
    input  textOverlayPkg::configWord configData,
    output textOverlayPkg::slotEntry [characterCount-1:0] slots,
    output logic glyphWrite,
    output textOverlayPkg::glyphRowAddress glyphWriteAddress,
    output textOverlayPkg::glyphRowBits glyphWriteRow
);
    import textOverlayPkg::*;

    localparam int indexBits = configAddressBits - 1;

    logic slotSpace;
    logic [indexBits-1:0] slotIndex;

    assign slotSpace = configAddress[configAddressBits-1];
    assign slotIndex = configAddress[indexBits-1:0];

    // one register per slot, out of range indices match nothing
    for (genvar i = 0; i < characterCount; i++) begin : slotRegisters
        always_ff @(posedge clock) begin
            if (reset) begin
                slots[i] <= '0;
            end else if (configWrite && slotSpace && slotIndex == indexBits'(i)) begin
                slots[i] <= configData.slot;
            end
        end
    end

    // glyph rows go out one cycle later
    always_ff @(posedge clock) begin
        if (reset) begin
            glyphWrite <= 1'b0;
        end else begin
            glyphWrite <= configWrite && !slotSpace;
        end
    end

    always_ff @(posedge clock) begin
        if (configWrite && !slotSpace) begin
            glyphWriteAddress <= configAddress[$bits(glyphRowAddress)-1:0];
            glyphWriteRow <= configData.glyph.row;  // upper bits of the word ignored
        end
    end

endmodule

// ==== verilog/fontMemory.sv ====
`timescale 1ns/1ns

module fontMemory (
    input  logic clock,
    input  logic glyphWrite,
    input  textOverlayPkg::glyphRowAddress glyphWriteAddress,
    input  textOverlayPkg::glyphRowBits glyphWriteRow,
    input  textOverlayPkg::glyphRowAddress glyphReadAddress,
    output textOverlayPkg::glyphRowBits glyphRow
);
    import textOverlayPkg::*;

    localparam int rowCount = 2 ** $bits(glyphRowAddress);

    glyphRowBits rows [rowCount];
    glyphRowAddress readAddress;

    always_ff @(posedge clock) begin
        if (glyphWrite) begin
            rows[glyphWriteAddress] <= glyphWriteRow;
        end
    end

    // registered address then registered data, like the block RAM
    always_ff @(posedge clock) begin
        readAddress <= glyphReadAddress;
        glyphRow <= rows[readAddress];
    end

endmodule

// ==== verilog/pixelCompositor.sv ====
`timescale 1ns/1ns

module pixelCompositor (
    input  logic clock,
    input  logic reset,
    input  logic hit,
    input  logic [textOverlayPkg::columnBits-1:0] hitColumn,
    input  logic [textOverlayPkg::colorBits-1:0] hitColor,
    input  textOverlayPkg::glyphRowBits glyphRow,
    input  logic [textOverlayPkg::displayXBits-1:0] delayedX,
    input  logic [textOverlayPkg::displayYBits-1:0] delayedY,
    input  logic delayedHsync,
    input  logic delayedVsync,
    input  logic delayedBlank,
    input  logic [textOverlayPkg::colorBits-1:0] delayedPixel,
    output logic [textOverlayPkg::displayXBits-1:0] displayXOut,
    output logic [textOverlayPkg::displayYBits-1:0] displayYOut,
    output logic hsyncOut,
    output logic vsyncOut,
    output logic blankOut,
    output logic [textOverlayPkg::colorBits-1:0] pixel
);
    import textOverlayPkg::*;

    logic [1:0] hitDelay;
    logic [columnBits-1:0] columnDelay [2];
    logic [colorBits-1:0] colorDelay [2];

    always_ff @(posedge clock) begin
        if (reset) begin
            hitDelay <= '0;
            columnDelay <= '{default: '0};
            colorDelay <= '{default: '0};
            displayXOut <= '0;
            displayYOut <= '0;
            hsyncOut <= 1'b0;
            vsyncOut <= 1'b0;
            blankOut <= 1'b0;
            pixel <= '0;
        end else begin
            hitDelay <= {hitDelay[0], hit};  // wait out the memory read
            columnDelay[0] <= hitColumn;
            columnDelay[1] <= columnDelay[0];
            colorDelay[0] <= hitColor;
            colorDelay[1] <= colorDelay[0];
            if (hitDelay[1] && glyphRow[columnDelay[1]]) begin
                pixel <= colorDelay[1];
            end else begin
                pixel <= delayedPixel;  // clear glyph bit or no slot
            end
            displayXOut <= delayedX;
            displayYOut <= delayedY;
            hsyncOut <= delayedHsync;
            vsyncOut <= delayedVsync;
            blankOut <= delayedBlank;
        end
    end

endmodule

// ==== verilog/textOverlayPkg.sv ====
package textOverlayPkg;

    // display and colour widths
    localparam int displayXBits = 12;
    localparam int displayYBits = 12;
    localparam int colorBits = 12;  // RGB444

    // character cell geometry
    localparam int glyphWidth = 18;
    localparam int glyphHeight = 32;
    localparam int rowBits = 5;
    localparam int columnBits = 5;
    localparam int codeBits = 7;  // 128 glyphs

    // input pixel to output pixel
    localparam int pipelineLatency = 5;

    // top bit selects slot space
    localparam int configAddressBits = 13;

    // code above row, one word per glyph row
    typedef logic [codeBits+rowBits-1:0] glyphRowAddress;

    // bit n is column n
    typedef logic [glyphWidth-1:0] glyphRowBits;

    typedef struct packed {
        logic enable;
        logic [displayXBits-1:0] x;
        logic [displayYBits-1:0] y;
        logic [codeBits-1:0] code;
        logic [colorBits-1:0] color;
    } slotEntry;

    // one configuration word, decoded by address space
    typedef union packed {
        slotEntry slot;
        struct packed {
            logic [$bits(slotEntry)-glyphWidth-1:0] padding;
            glyphRowBits row;
        } glyph;
    } configWord;

endpackage

// ==== verilog/textOverlayTop.sv ====
`timescale 1ns/1ns

module textOverlayTop #(
    parameter int characterCount = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic [textOverlayPkg::displayXBits-1:0] displayX,
    input  logic [textOverlayPkg::displayYBits-1:0] displayY,
    input  logic hsync,
    input  logic vsync,
    input  logic blank,
    input  logic [textOverlayPkg::colorBits-1:0] previousPixel,
    input  logic configWrite,
    input  logic [textOverlayPkg::configAddressBits-1:0] configAddress,
    input  textOverlayPkg::configWord configData,
    output logic [textOverlayPkg::displayXBits-1:0] displayXOut,
    output logic [textOverlayPkg::displayYBits-1:0] displayYOut,
    output logic hsyncOut,
    output logic vsyncOut,
    output logic blankOut,
    output logic [textOverlayPkg::colorBits-1:0] pixel
);
    import textOverlayPkg::*;

    slotEntry [characterCount-1:0] slots;

    logic glyphWrite;
    glyphRowAddress glyphWriteAddress;
    glyphRowBits glyphWriteRow;
    glyphRowAddress glyphReadAddress;
    glyphRowBits glyphRow;

    logic hit;
    logic [columnBits-1:0] hitColumn;
    logic [colorBits-1:0] hitColor;

    logic [displayXBits-1:0] delayedX;
    logic [displayYBits-1:0] delayedY;
    logic delayedHsync;
    logic delayedVsync;
    logic delayedBlank;
    logic [colorBits-1:0] delayedPixel;

    characterTable #(
        .characterCount(characterCount)
    ) table0 (
        .clock(clock),
        .reset(reset),
        .configWrite(configWrite),
        .configAddress(configAddress),
        .configData(configData),
        .slots(slots),
        .glyphWrite(glyphWrite),
        .glyphWriteAddress(glyphWriteAddress),
        .glyphWriteRow(glyphWriteRow)
    );

    characterLocator #(
        .characterCount(characterCount)
    ) locator0 (
        .clock(clock),
        .reset(reset),
        .displayX(displayX),
        .displayY(displayY),
        .slots(slots),
        .glyphReadAddress(glyphReadAddress),
        .hit(hit),
        .hitColumn(hitColumn),
        .hitColor(hitColor)
    );

    fontMemory font0 (
        .clock(clock),
        .glyphWrite(glyphWrite),
        .glyphWriteAddress(glyphWriteAddress),
        .glyphWriteRow(glyphWriteRow),
        .glyphReadAddress(glyphReadAddress),
        .glyphRow(glyphRow)
    );

    // compositor adds the last register
    videoDelayLine #(
        .depth(pipelineLatency - 1)
    ) delay0 (
        .clock(clock),
        .reset(reset),
        .displayX(displayX),
        .displayY(displayY),
        .hsync(hsync),
        .vsync(vsync),
        .blank(blank),
        .previousPixel(previousPixel),
        .delayedX(delayedX),
        .delayedY(delayedY),
        .delayedHsync(delayedHsync),
        .delayedVsync(delayedVsync),
        .delayedBlank(delayedBlank),
        .delayedPixel(delayedPixel)
    );

    pixelCompositor compositor0 (
        .clock(clock),
        .reset(reset),
        .hit(hit),
        .hitColumn(hitColumn),
        .hitColor(hitColor),
        .glyphRow(glyphRow),
        .delayedX(delayedX),
        .delayedY(delayedY),
        .delayedHsync(delayedHsync),
        .delayedVsync(delayedVsync),
        .delayedBlank(delayedBlank),
        .delayedPixel(delayedPixel),
        .displayXOut(displayXOut),
        .displayYOut(displayYOut),
        .hsyncOut(hsyncOut),
        .vsyncOut(vsyncOut),
        .blankOut(blankOut),
        .pixel(pixel)
    );

endmodule

// ==== verilog/videoDelayLine.sv ====
`timescale 1ns/1ns

module videoDelayLine #(
    parameter int depth = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic [textOverlayPkg::displayXBits-1:0] displayX,
    input  logic [textOverlayPkg::displayYBits-1:0] displayY,
    input  logic hsync,
    input  logic vsync,
    input  logic blank,
    input  logic [textOverlayPkg::colorBits-1:0] previousPixel,
    output logic [textOverlayPkg::displayXBits-1:0] delayedX,
    output logic [textOverlayPkg::displayYBits-1:0] delayedY,
    output logic delayedHsync,
    output logic delayedVsync,
    output logic delayedBlank,
    output logic [textOverlayPkg::colorBits-1:0] delayedPixel
);
    import textOverlayPkg::*;

    localparam int streamBits = displayXBits + displayYBits + 3 + colorBits;

    logic [streamBits-1:0] stages [depth];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= {displayX, displayY, hsync, vsync, blank, previousPixel};
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign {delayedX, delayedY, delayedHsync, delayedVsync, delayedBlank, delayedPixel} =
        stages[depth-1];

endmodule
